//--- hw/display_timing.sv
// display timing generator
// signed raster position with data enable, frame and line pulses

`default_nettype none
`timescale 1ns/1ps

module display_timing (
    input  wire logic            clk_sys,
    input  wire logic            rst_n_i,
    output      fb_pkg::raster_t raster_o
);
    import fb_pkg::*;

    logic signed [CORDW-1:0] sx_nxt;
    logic signed [CORDW-1:0] sy_nxt;

    // next position, wraps at end of line and frame
    always_comb begin
        if (raster_o.sx == H_ACTIVE - 1) begin
            sx_nxt = CORDW'(H_START);  // back to blanking
            if (raster_o.sy == V_ACTIVE - 1) begin
                sy_nxt = CORDW'(V_START);
            end else begin
                sy_nxt = raster_o.sy + CORDW'(1);
            end
        end else begin
            sx_nxt = raster_o.sx + CORDW'(1);
            sy_nxt = raster_o.sy;
        end
    end

    // everything registered so pulses line up with the position
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            raster_o.sx    <= CORDW'(H_START);
            raster_o.sy    <= CORDW'(V_START);
            raster_o.de    <= 1'b0;
            raster_o.frame <= 1'b0;
            raster_o.line  <= 1'b0;
        end else begin
            raster_o.sx    <= sx_nxt;
            raster_o.sy    <= sy_nxt;
            raster_o.de    <= (sx_nxt >= 0) && (sy_nxt >= 0);
            raster_o.frame <= (sx_nxt == H_START) && (sy_nxt == V_START);
            raster_o.line  <= (sx_nxt == H_START);  // every line incl blanking
        end
    end

endmodule

`default_nettype wire

//--- hw/fb_display_top.sv
// framebuffer display top
// timing, framebuffer, fizzle fade, scaler and palette

`default_nettype none
`timescale 1ns/1ps

module fb_display_top (
    input  wire logic               clk_sys,
    input  wire logic               rst_n_i,
    input  wire fb_pkg::fb_wr_t     load_i,
    output      fb_pkg::pixel_out_t pix_o,
    output      logic               fade_done_o
);
    import fb_pkg::*;

    raster_t             raster;
    fb_wr_t              fb_wr;      // load or fade write
    logic [FB_ADDRW-1:0] rd_addr;
    logic [CIDXW-1:0]    rd_colr;
    logic [CIDXW-1:0]    cidx;
    logic                cidx_valid;

    display_timing u_timing (
        .clk_sys  (clk_sys),
        .rst_n_i  (rst_n_i),
        .raster_o (raster)
    );

    fizzle_fade u_fade (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .frame_i     (raster.frame),
        .load_i      (load_i),
        .fb_wr_o     (fb_wr),
        .fade_done_o (fade_done_o)
    );

    fb_ram u_ram (
        .clk_sys   (clk_sys),
        .wr_i      (fb_wr),
        .rd_addr_i (rd_addr),
        .rd_colr_o (rd_colr)
    );

    line_scaler u_scaler (
        .clk_sys      (clk_sys),
        .rst_n_i      (rst_n_i),
        .raster_i     (raster),
        .rd_addr_o    (rd_addr),
        .rd_colr_i    (rd_colr),
        .cidx_o       (cidx),
        .cidx_valid_o (cidx_valid)
    );

    grey_palette u_palette (
        .clk_sys      (clk_sys),
        .rst_n_i      (rst_n_i),
        .raster_i     (raster),
        .cidx_i       (cidx),
        .cidx_valid_i (cidx_valid),
        .pix_o        (pix_o)
    );

endmodule

`default_nettype wire

//--- hw/fb_pkg.sv
// framebuffer display package
// raster, framebuffer, fade and colour constants plus the shared structs

`default_nettype none

package fb_pkg;

    // raster geometry, blanking sits at negative coordinates
    localparam int CORDW    = 8;                   // signed coordinate width
    localparam int H_ACTIVE = 16;                  // active pixels per line
    localparam int H_TOTAL  = 24;                  // pixels per line
    localparam int V_ACTIVE = 12;                  // active lines
    localparam int V_TOTAL  = 16;                  // lines per frame
    localparam int H_START  = H_ACTIVE - H_TOTAL;  // first sx, -8
    localparam int V_START  = V_ACTIVE - V_TOTAL;  // first sy, -4

    // framebuffer
    localparam int FB_WIDTH  = 8;
    localparam int FB_HEIGHT = 6;
    localparam int FB_SCALE  = 2;                     // pixel repeat in x and y
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 48
    localparam int FB_ADDRW  = 6;
    localparam int CIDXW     = 4;                     // colour index bits
    localparam int LB_LAT    = 2;                     // scaler lookup latency

    // fade control
    localparam int FADE_WAIT   = 3;                 // frame pulses before fade
    localparam int FADE_RATE   = 4;                 // cycles per lfsr step
    localparam int LFSR_LEN    = 6;
    localparam logic [LFSR_LEN-1:0] LFSR_TAPS = 6'b110000;  // x^6+x^5+1
    localparam logic [LFSR_LEN-1:0] LFSR_SEED = 6'd1;
    localparam int LFSR_STEPS  = 2**LFSR_LEN - 1;   // full period, 63

    // colour
    localparam int CHANW = 8;                       // output channel width
    localparam logic [CIDXW-1:0] FADE_COLR = '0;    // fade writes black

    typedef struct packed {
        logic signed [CORDW-1:0] sx;
        logic signed [CORDW-1:0] sy;
        logic                    de;     // active video
        logic                    frame;  // first pixel of frame
        logic                    line;   // first pixel of line
    } raster_t;

    typedef struct packed {
        logic signed [CORDW-1:0] sx;
        logic signed [CORDW-1:0] sy;
        logic                    de;
        logic                    frame;
        logic [CHANW-1:0]        r;
        logic [CHANW-1:0]        g;
        logic [CHANW-1:0]        b;
    } pixel_out_t;

    typedef struct packed {
        logic                we;
        logic [FB_ADDRW-1:0] addr;
        logic [CIDXW-1:0]    colr;
    } fb_wr_t;

endpackage

`default_nettype wire

//--- hw/fb_ram.sv
// framebuffer memory
// simple dual-port, one write port and a registered read port

`default_nettype none
`timescale 1ns/1ps

module fb_ram (
    input  wire logic                       clk_sys,
    input  wire fb_pkg::fb_wr_t             wr_i,
    input  wire logic [fb_pkg::FB_ADDRW-1:0] rd_addr_i,
    output      logic [fb_pkg::CIDXW-1:0]    rd_colr_o
);
    import fb_pkg::*;

    logic [CIDXW-1:0] mem [FB_PIXELS];  // one colour index per pixel

    always_ff @(posedge clk_sys) begin
        if (wr_i.we) begin
            mem[wr_i.addr] <= wr_i.colr;
        end
        rd_colr_o <= mem[rd_addr_i];  // 1 cycle read latency
    end

endmodule

`default_nettype wire

//--- hw/fizzle_fade.sv
// fizzle fade controller
// waits some frames, then blacks out pixels in lfsr order
// owns the framebuffer write port and passes image loads through until fade

`default_nettype none
`timescale 1ns/1ps

module fizzle_fade (
    input  wire logic           clk_sys,
    input  wire logic           rst_n_i,
    input  wire logic           frame_i,
    input  wire fb_pkg::fb_wr_t load_i,
    output      fb_pkg::fb_wr_t fb_wr_o,
    output      logic           fade_done_o
);
    import fb_pkg::*;

    logic [$clog2(FADE_WAIT+1)-1:0] cnt_wait;   // saturating frame count
    logic [$clog2(FADE_RATE)-1:0]   cnt_rate;
    logic [LFSR_LEN-1:0]            lfsr;
    logic [LFSR_LEN-1:0]            cnt_step;   // lfsr steps taken
    logic                           fade_act;
    logic                           step;
    logic                           wr_we_q;
    logic [FB_ADDRW-1:0]            wr_addr_q;
    logic [CIDXW-1:0]               wr_colr_q;

    always_comb begin
        fade_act = (cnt_wait == FADE_WAIT);
        step     = fade_act && !fade_done_o && (cnt_rate == FADE_RATE - 1);
    end

    // control side of the fade
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_wait    <= '0;
            cnt_rate    <= '0;
            lfsr        <= LFSR_SEED;
            cnt_step    <= '0;
            fade_done_o <= 1'b0;
            wr_we_q     <= 1'b0;
        end else begin
            if (frame_i && !fade_act) cnt_wait <= cnt_wait + 1'b1;
            if (fade_act && !fade_done_o) cnt_rate <= cnt_rate + 1'b1;  // wraps at rate
            if (step) begin
                // galois step shifts right and folds in the taps on a one out
                lfsr     <= lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
                cnt_step <= cnt_step + 1'b1;
                if (cnt_step == LFSR_STEPS - 1) fade_done_o <= 1'b1;  // sticky
            end
            if (fade_act) begin
                wr_we_q <= step && (lfsr <= FB_PIXELS);  // skip beyond image
            end else begin
                wr_we_q <= load_i.we;  // load strobe delayed by 1
            end
        end
    end

    // write address and colour
    always_ff @(posedge clk_sys) begin
        if (fade_act) begin
            wr_addr_q <= lfsr - 1'b1;  // lfsr never 0 so 0..62
            wr_colr_q <= FADE_COLR;
        end else begin
            wr_addr_q <= load_i.addr;
            wr_colr_q <= load_i.colr;
        end
    end

    always_comb begin
        fb_wr_o.we   = wr_we_q;
        fb_wr_o.addr = wr_addr_q;
        fb_wr_o.colr = wr_colr_q;
    end

endmodule

`default_nettype wire

//--- hw/grey_palette.sv
// grey palette and output stage
// 16-level grey lookup, blanking and a registered pixel output

`default_nettype none
`timescale 1ns/1ps

module grey_palette (
    input  wire logic                     clk_sys,
    input  wire logic                     rst_n_i,
    input  wire fb_pkg::raster_t          raster_i,
    input  wire logic [fb_pkg::CIDXW-1:0] cidx_i,
    input  wire logic                     cidx_valid_i,
    output      fb_pkg::pixel_out_t       pix_o
);
    import fb_pkg::*;

    raster_t          rdly [LB_LAT];  // position delayed to meet the index
    logic [CHANW-1:0] grey;

    always_comb begin
        if (rdly[LB_LAT-1].de && cidx_valid_i) begin
            grey = {(CHANW/CIDXW){cidx_i}};  // both nibbles = index
        end else begin
            grey = '0;  // blank
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < LB_LAT; i++) rdly[i] <= '0;
            pix_o <= '0;
        end else begin
            rdly[0] <= raster_i;
            for (int i = 1; i < LB_LAT; i++) rdly[i] <= rdly[i-1];
            pix_o.sx    <= rdly[LB_LAT-1].sx;
            pix_o.sy    <= rdly[LB_LAT-1].sy;
            pix_o.de    <= rdly[LB_LAT-1].de;
            pix_o.frame <= rdly[LB_LAT-1].frame;
            pix_o.r     <= grey;  // grey, same on all channels
            pix_o.g     <= grey;
            pix_o.b     <= grey;
        end
    end

endmodule

`default_nettype wire

//--- hw/line_scaler.sv
// line scaler
// fills a double-banked linebuffer from the framebuffer one line early
// and repeats pixels FB_SCALE times in both directions

`default_nettype none
`timescale 1ns/1ps

module line_scaler (
    input  wire logic                        clk_sys,
    input  wire logic                        rst_n_i,
    input  wire fb_pkg::raster_t             raster_i,
    output      logic [fb_pkg::FB_ADDRW-1:0] rd_addr_o,
    input  wire logic [fb_pkg::CIDXW-1:0]    rd_colr_i,
    output      logic [fb_pkg::CIDXW-1:0]    cidx_o,
    output      logic                        cidx_valid_o
);
    import fb_pkg::*;

    localparam int FB_XW = $clog2(FB_WIDTH);

    logic [CIDXW-1:0]            lb [2][FB_WIDTH];  // two banks of one image row
    logic [$clog2(FB_SCALE)-1:0] grp_line;          // line within the group
    logic [$clog2(FB_SCALE)-1:0] grp_line_nxt;
    logic                        bank_q;            // bank being displayed
    logic                        fill_go;
    logic                        swap;
    logic                        fill_act;
    logic [FB_XW-1:0]            fill_x;
    logic                        wr_en_q;           // ram data valid
    logic [FB_XW-1:0]            wr_idx_q;
    logic [CORDW-1:0]            sx_u;
    logic [FB_XW-1:0]            lb_idx;
    logic                        in_area;
    logic [CIDXW-1:0]            lb_rd_q;
    logic                        valid_q;

    always_comb begin
        // blanking lines count as the last line of a group
        if (raster_i.sy < 0) begin
            grp_line_nxt = $bits(grp_line)'(FB_SCALE - 1);
        end else if (grp_line == FB_SCALE - 1) begin
            grp_line_nxt = '0;
        end else begin
            grp_line_nxt = grp_line + 1'b1;
        end
        // fill on the line before a group, swap when it starts
        fill_go = raster_i.line && (raster_i.sy >= -1) && (raster_i.sy < V_ACTIVE - 1)
                  && (grp_line_nxt == FB_SCALE - 1);
        swap    = raster_i.line && (raster_i.sy >= 0) && (grp_line_nxt == 0);
        sx_u    = raster_i.sx;  // only used inside the area
        lb_idx  = FB_XW'(sx_u / FB_SCALE);
        in_area = (raster_i.sx >= 0) && (raster_i.sx < H_ACTIVE)
                  && (raster_i.sy >= 0) && (raster_i.sy < V_ACTIVE);
    end

    // group tracking and framebuffer reads
    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grp_line  <= '0;
            bank_q    <= 1'b0;
            fill_act  <= 1'b0;
            fill_x    <= '0;
            rd_addr_o <= '0;
            wr_en_q   <= 1'b0;
        end else begin
            if (raster_i.line) grp_line <= grp_line_nxt;
            if (swap) bank_q <= !bank_q;
            if (fill_go) begin
                fill_act <= 1'b1;
                fill_x   <= '0;
            end else if (fill_act) begin
                fill_x <= fill_x + 1'b1;
                if (fill_x == FB_WIDTH - 1) fill_act <= 1'b0;  // row done
            end
            if (raster_i.frame) begin
                rd_addr_o <= '0;  // image restarts at row 0
            end else if (fill_act) begin
                rd_addr_o <= rd_addr_o + 1'b1;  // rows are contiguous
            end
            wr_en_q <= fill_act;
        end
    end

    // linebuffer write into the idle bank, read from the active bank
    always_ff @(posedge clk_sys) begin
        wr_idx_q <= fill_x;
        if (wr_en_q) lb[!bank_q][wr_idx_q] <= rd_colr_i;
        lb_rd_q <= lb[bank_q][lb_idx];  // lookahead stage 1
        cidx_o  <= lb_rd_q;             // stage 2
    end

    always_ff @(posedge clk_sys or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q      <= 1'b0;
            cidx_valid_o <= 1'b0;
        end else begin
            valid_q      <= in_area;
            cidx_valid_o <= valid_q;  // matches cidx_o
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# verilator build and run of the framebuffer display testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_fb_display -f sim.f \
    && ./obj_dir/Vtb_fb_display | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
    && echo "simulation log shows a pass" \
    || { echo "simulation log shows no pass"; exit 1; }

//--- sim.f
hw/fb_pkg.sv
hw/display_timing.sv
hw/fb_ram.sv
hw/fizzle_fade.sv
hw/line_scaler.sv
hw/grey_palette.sv
hw/fb_display_top.sv
verification/fb_display_properties.sv
verification/tb_fb_display.sv

//--- verification/fb_display_properties.sv
// bound assertions on the display top outputs
// frame and de relation, fade done stickiness, grey channels

`default_nettype none
`timescale 1ns/1ps

module fb_display_props (
    input wire logic               clk_sys,
    input wire logic               rst_n_i,
    input wire fb_pkg::pixel_out_t pix_i,
    input wire logic               fade_done_i
);
    import fb_pkg::*;

    frame_in_blank: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
        pix_i.frame |-> !pix_i.de)  // pulse sits at the first blanking pixel
        else $error("frame pulse together with de");

    de_rise_active: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
        $rose(pix_i.de) |-> !pix_i.sy[CORDW-1])  // sign bit clear
        else $error("de rose on a blanking line");

    done_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
        fade_done_i |=> fade_done_i)
        else $error("fade_done dropped after rising");

    // case equality, so unloaded memory cannot trip it
    grey_channels: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
        (pix_i.r === pix_i.g) && (pix_i.g === pix_i.b))
        else $error("r, g and b differ");

endmodule

`default_nettype wire

//--- verification/fb_display_stimulus.mem
// columns: colour index, expected grey byte
// one line per image pixel, row by row from the top left
3 33
a aa
1 11
8 88
f ff
6 66
d dd
4 44
b bb
2 22
9 99
0 00
7 77
e ee
5 55
c cc
4 44
b bb
2 22
9 99
0 00
7 77
e ee
5 55
c cc
3 33
a aa
1 11
8 88
f ff
6 66
d dd
5 55
c cc
3 33
a aa
1 11
8 88
f ff
6 66
d dd
4 44
b bb
2 22
9 99
0 00
7 77
e ee

//--- verification/tb_fb_display.sv
// testbench for the framebuffer display top
// loads the image, then checks picture, blanking, raster shape and the fizzle fade

`default_nettype none
`timescale 1ns/1ps

module tb_fb_display;
    import fb_pkg::*;

    localparam int CLK_NS     = 20;
    localparam int RST_CYC    = 5;
    localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;    // 384 samples per frame
    localparam int DE_CYC     = H_ACTIVE * V_ACTIVE;  // 192 active samples
    localparam int FADE_FRM   = FADE_WAIT;            // output frame where fading runs
    localparam int END_FRM    = 6;                    // frames 1..5 fully checked
    localparam int TIMEOUT_NS = (RST_CYC + 8 * FRAME_CYC + 200) * CLK_NS;
    localparam logic [31:0] RAND_TAPS = 32'h8020_0003;  // x^32+x^22+x^2+x+1
    localparam logic [31:0] RAND_SEED = 32'd71998;

    logic       clk_sys;
    logic       rst_n_i;
    fb_wr_t     load_i;
    pixel_out_t pix_o;
    logic       fade_done_o;

    logic [7:0]  stim_mem [2*FB_PIXELS];  // colour index, grey byte, per pixel
    logic [31:0] rand_state;
    int          frm;                     // output frame pulses seen
    int          smp_cnt;
    int          de_cnt;
    int          done_frm;                // frame in which fade_done_o rose
    int          dark_frm [FB_PIXELS];    // first frame a pixel showed black
    int          chk_cnt;
    int          err_val;
    int          err_other;

    initial clk_sys = 1'b0;
    always #(CLK_NS/2) clk_sys = ~clk_sys;

    fb_display_top uut (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .load_i      (load_i),
        .pix_o       (pix_o),
        .fade_done_o (fade_done_o)
    );

    bind fb_display_top fb_display_props u_props (
        .clk_sys     (clk_sys),
        .rst_n_i     (rst_n_i),
        .pix_i       (pix_o),
        .fade_done_i (fade_done_o)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ RAND_TAPS) : (s >> 1);  // galois, shift right
    endfunction

    // one lfsr step per bit taken
    task automatic take_rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val        = (val << 1) | int'(rand_state[0]);
            rand_state = lfsr_next(rand_state);
        end
    endtask

    task automatic report_value(input string test, input int exp, input int act);
        err_val++;
        $display("Error [%s] expected %0h actual %0h (t=%0t)", test, exp, act, $time);
    endtask

    task automatic report_fault(input string what);
        err_other++;
        $display("Error: %s (t=%0t)", what, $time);
    endtask

    initial begin
        int gap;
        rst_n_i    = 1'b0;
        load_i     = '0;
        rand_state = RAND_SEED;
        frm        = 0;
        smp_cnt    = 0;
        de_cnt     = 0;
        done_frm   = -1;  // not yet
        chk_cnt    = 0;
        err_val    = 0;
        err_other  = 0;
        for (int p = 0; p < FB_PIXELS; p++) begin
            dark_frm[p] = END_FRM + 1;
        end
        $readmemh("verification/fb_display_stimulus.mem", stim_mem);
        repeat (RST_CYC) @(negedge clk_sys);
        rst_n_i = 1'b1;
        // image load in frame 0, 0..3 idle cycles after each write
        for (int p = 0; p < FB_PIXELS; p++) begin
            @(negedge clk_sys);
            load_i.we   = 1'b1;
            load_i.addr = FB_ADDRW'(p);
            load_i.colr = stim_mem[2*p][CIDXW-1:0];
            take_rand_bits(2, gap);
            for (int i = 0; i < gap; i++) begin
                @(negedge clk_sys);
                load_i.we = 1'b0;
            end
        end
        @(negedge clk_sys);
        load_i = '0;
        if (frm != 0) report_fault("image load ran past frame 0");
        wait (frm == END_FRM);
        $display("Checks %0d, errors %0d (wrong value %0d, other %0d)",
                 chk_cnt, err_val + err_other, err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // output scoreboard, samples mid-cycle
    always @(negedge clk_sys) begin : monitor
        int         sx;
        int         sy;
        int         p;
        logic [7:0] exp_grey;
        if (rst_n_i) begin
            sx = pix_o.sx;
            sy = pix_o.sy;
            if (fade_done_o && done_frm < 0) begin
                done_frm = frm;
                if (frm < FADE_FRM) report_fault("fade_done_o rose before the fade frame");
            end
            if (pix_o.frame) begin
                chk_cnt++;
                if (sx != H_START || sy != V_START) begin
                    report_fault($sformatf("frame pulse at %0d,%0d, not at first pixel", sx, sy));
                end
                if (frm > 0) begin  // frame 0 starts at reset, not at a pulse
                    if (smp_cnt != FRAME_CYC) report_value("frame length", FRAME_CYC, smp_cnt);
                    if (de_cnt != DE_CYC) report_value("de per frame", DE_CYC, de_cnt);
                end
                frm++;
                smp_cnt = 0;
                de_cnt  = 0;
                if (frm == FADE_FRM + 2 && done_frm < 0) begin
                    report_fault("fade_done_o did not rise within two frames of the fade start");
                end
            end
            smp_cnt++;
            if (!pix_o.de) begin
                chk_cnt++;
                if ({pix_o.r, pix_o.g, pix_o.b} != '0) begin
                    report_value("blanking", 0, int'({pix_o.r, pix_o.g, pix_o.b}));
                end
            end else begin
                de_cnt++;
                if (sx < 0 || sx >= H_ACTIVE || sy < 0 || sy >= V_ACTIVE) begin
                    report_fault($sformatf("de high outside the active area at %0d,%0d", sx, sy));
                end else if (frm > 0) begin
                    p        = (sy / FB_SCALE) * FB_WIDTH + sx / FB_SCALE;
                    exp_grey = stim_mem[2*p+1];
                    chk_cnt++;
                    if (frm < FADE_FRM) begin
                        if (pix_o.r != exp_grey) report_value("image red", exp_grey, pix_o.r);
                        if (pix_o.g != exp_grey) report_value("image green", exp_grey, pix_o.g);
                        if (pix_o.b != exp_grey) report_value("image blue", exp_grey, pix_o.b);
                    end else if (done_frm >= 0 && frm > done_frm) begin
                        if (pix_o.r != 0) report_value("after fade", 0, pix_o.r);
                    end else begin
                        if (pix_o.r != exp_grey && pix_o.r != 0) begin
                            report_value("fade", exp_grey, pix_o.r);
                        end
                        if (pix_o.r == 0 && exp_grey != 0 && dark_frm[p] > frm) dark_frm[p] = frm;
                        if (pix_o.r == exp_grey && exp_grey != 0 && dark_frm[p] < frm) begin
                            report_fault($sformatf("pixel %0d came back after going black", p));
                        end
                    end
                    if (pix_o.g != pix_o.r) report_value("green vs red", pix_o.r, pix_o.g);
                    if (pix_o.b != pix_o.r) report_value("blue vs red", pix_o.r, pix_o.b);
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Error: timeout, output frame %0d never reached", END_FRM);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
